/* sim/parity_err_tests.txt */
# name op addr data par | expected pes pea block rerr par_err
# ops: bus local both pes_rd pea_rd test_on test_off, values in hex, flags in binary
bus_good     bus      000100 0000 3  0000 000000 0 0 0
local_good   local    000200 0103 1  0000 000000 0 0 0
local_b0     local    001234 0000 2  0001 001234 0 0 1
local_b1     local    00abcd 0000 1  0002 00abcd 0 0 1
bus_b0       bus      100010 0000 2  8001 100010 1 1 1
bus_blocked  bus      200020 0000 0  c001 100010 1 1 1
good_blocked local    000300 0103 1  c001 100010 1 1 0
pes_read     pes_rd   000000 0000 0  8001 100010 1 1 0
pea_read     pea_rd   000000 0000 0  8001 100010 0 1 0
bus_both     bus      300030 0000 0  8003 300030 1 1 1
local_blk    local    000400 0000 2  c003 300030 1 0 1
pea_read2    pea_rd   000000 0000 0  c003 300030 0 0 0
pes_read2    pes_rd   000000 0000 0  8003 300030 0 0 0
both_fail    both     000500 0000 2  0001 000500 0 0 1
bus_b1       bus      400040 0000 1  8002 400040 1 1 1
enter_test   test_on  000000 0000 0  8002 400040 0 0 0
test_bus     bus      500050 0000 0  8002 400040 0 0 0
test_local   local    600060 0000 2  8002 400040 0 0 0
leave_test   test_off 000000 0000 0  8002 400040 0 0 0
after_test   bus      700070 0000 0  8003 700070 1 1 1
pea_read3    pea_rd   000000 0000 0  8003 700070 0 1 0
local_good2  local    000800 0103 1  8003 700070 0 1 0
local_both   local    000900 0000 0  0003 000900 0 0 1
pes_read3    pes_rd   000000 0000 0  0003 000900 0 0 0

/* sim.f */
hdl/parity_pkg.sv
hdl/parity_err_if.sv
hdl/parity_check.sv
hdl/parity_err_ctl.sv
hdl/parity_err_regs.sv
hdl/parity_err_top.sv
sim/parity_err_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module parity_err_tb \
  -Mdir obj_dir -o parity_err_sim

# A failing run still leaves its log for the search below
./obj_dir/parity_err_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation FAILED"
  exit 1
fi

/* sim/parity_err_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module parity_err_tb;
  import parity_pkg::*;

  typedef logic [127:0] text_t;             // Test names and operations, right justified

  logic                 clk;
  logic                 rst_n;
  logic                 test;
  logic                 bus_valid;
  logic [data_w-1:0]    bus_data;
  logic [n_bytes-1:0]   bus_par;
  logic [addr_w-1:0]    bus_addr;
  logic                 local_valid;
  logic [data_w-1:0]    local_data;
  logic [n_bytes-1:0]   local_par;
  logic [addr_w-1:0]    local_addr;
  logic                 pes_rd;
  logic                 pea_rd;
  pes_t                 pes;
  logic [addr_w-1:0]    pea;
  logic                 block;
  logic                 rerr;
  logic                 par_err;

  // One entry per line of the tests file
  text_t              q_name [$];
  text_t              q_op [$];
  logic [addr_w-1:0]  q_addr [$];
  logic [data_w-1:0]  q_data [$];
  logic [n_bytes-1:0] q_par [$];
  pes_t               q_pes [$];
  logic [addr_w-1:0]  q_pea [$];
  logic               q_block [$];
  logic               q_rerr [$];
  logic               q_perr [$];

  integer seed;
  int     cycle_cnt;
  int     cycle_limit;

  parity_err_top dut_i (
    .clk (clk), .rst_n (rst_n), .test (test),
    .bus_valid (bus_valid), .bus_data (bus_data), .bus_par (bus_par), .bus_addr (bus_addr),
    .local_valid (local_valid), .local_data (local_data), .local_par (local_par),
    .local_addr (local_addr), .pes_rd (pes_rd), .pea_rd (pea_rd),
    .pes (pes), .pea (pea), .block (block), .rerr (rerr), .par_err (par_err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                  // 8 ns period
  end

  // Run guard, limit set once the tests are loaded
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: run went past %0d clock cycles", cycle_limit);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_pes(input text_t name, input pes_t exp, input pes_t act);
    if (exp !== act) begin
      $display("ERROR %0s pes: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input text_t name, input logic [addr_w-1:0] exp,
                            input logic [addr_w-1:0] act);
    if (exp !== act) begin
      $display("ERROR %0s pea: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input text_t name, input text_t what, input logic exp,
                            input logic act);
    if (exp !== act) begin
      $display("ERROR %0s %0s: expected %b, actual %b", name, what, exp, act);
      abort_run();
    end
  endtask

  // Parse the tests file, lines that do not fill all ten columns are skipped
  task automatic load_tests();
    int                 fd;
    int                 n;
    logic [8*200-1:0]   line_buf;
    text_t              name;
    text_t              op;
    logic [addr_w-1:0]  addr;
    logic [data_w-1:0]  data;
    logic [n_bytes-1:0] par;
    pes_t               e_pes;
    logic [addr_w-1:0]  e_pea;
    logic               e_block;
    logic               e_rerr;
    logic               e_perr;
    fd = $fopen("sim/parity_err_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the tests file sim/parity_err_tests.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      if ($fgets(line_buf, fd) == 0)
        break;
      n = $sscanf(line_buf, "%s %s %h %h %h %h %h %b %b %b", name, op, addr, data, par,
                  e_pes, e_pea, e_block, e_rerr, e_perr);
      if (n == 10) begin
        q_name.push_back(name);
        q_op.push_back(op);
        q_addr.push_back(addr);
        q_data.push_back(data);
        q_par.push_back(par);
        q_pes.push_back(e_pes);
        q_pea.push_back(e_pea);
        q_block.push_back(e_block);
        q_rerr.push_back(e_rerr);
        q_perr.push_back(e_perr);
      end
    end
    $fclose(fd);
  endtask

  // Valid and reads low, random junk on the data lines
  task automatic drive_idle();
    logic [31:0] r;
    bus_valid   = 1'b0;
    local_valid = 1'b0;
    pes_rd      = 1'b0;
    pea_rd      = 1'b0;
    r = $random(seed);
    bus_data   = r[15:0];
    local_data = r[31:16];
    r = $random(seed);
    bus_addr  = r[23:0];
    bus_par   = r[25:24];
    local_par = r[27:26];
    r = $random(seed);
    local_addr = r[23:0];
  endtask

  task automatic drive_op(input int i);
    drive_idle();
    if (q_op[i] == text_t'("bus")) begin
      bus_valid = 1'b1;
      bus_addr  = q_addr[i];
      bus_data  = q_data[i];
      bus_par   = q_par[i];
    end else if (q_op[i] == text_t'("local")) begin
      local_valid = 1'b1;
      local_addr  = q_addr[i];
      local_data  = q_data[i];
      local_par   = q_par[i];
    end else if (q_op[i] == text_t'("both")) begin
      local_valid = 1'b1;
      local_addr  = q_addr[i];
      local_data  = q_data[i];
      local_par   = q_par[i];
      bus_valid   = 1'b1;
      bus_addr    = q_addr[i] ^ 24'hff0000; // Bus side differs in address
      bus_data    = q_data[i];
      bus_par     = ~q_par[i];              // and in which byte fails
    end else if (q_op[i] == text_t'("pes_rd")) begin
      pes_rd = 1'b1;
    end else if (q_op[i] == text_t'("pea_rd")) begin
      pea_rd = 1'b1;
    end else if (q_op[i] == text_t'("test_on")) begin
      test = 1'b1;                          // Level, held until test_off
    end else if (q_op[i] == text_t'("test_off")) begin
      test = 1'b0;
    end else begin
      $display("Unknown operation %0s in test %0s", q_op[i], q_name[i]);
      abort_run();
    end
  endtask

  initial begin
    seed        = 32'hb30f_e7ca;
    cycle_cnt   = 0;
    cycle_limit = 50;
    rst_n       = 1'b0;
    test        = 1'b0;
    drive_idle();
    load_tests();
    cycle_limit = q_name.size() * 4 + 50;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_pes(text_t'("reset"), '0, pes);
    check_addr(text_t'("reset"), '0, pea);
    check_flag(text_t'("reset"), text_t'("block"), 1'b0, block);
    check_flag(text_t'("reset"), text_t'("rerr"), 1'b0, rerr);
    check_flag(text_t'("reset"), text_t'("par_err"), 1'b0, par_err);
    for (int i = 0; i < q_name.size(); i++) begin
      drive_op(i);                          // Cycle T
      @(posedge clk);                       // Checker registers the report
      @(negedge clk);
      drive_idle();
      @(posedge clk);                       // Control and registers act
      @(negedge clk);
      check_pes(q_name[i], q_pes[i], pes);
      check_addr(q_name[i], q_pea[i], pea);
      check_flag(q_name[i], text_t'("block"), q_block[i], block);
      check_flag(q_name[i], text_t'("rerr"), q_rerr[i], rerr);
      check_flag(q_name[i], text_t'("par_err"), q_perr[i], par_err);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/parity_err_top.sv */
`timescale 1ns/100ps
`default_nettype none

module parity_err_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           test,
  input  logic                           bus_valid,
  input  logic [parity_pkg::data_w-1:0]  bus_data,
  input  logic [parity_pkg::n_bytes-1:0] bus_par,
  input  logic [parity_pkg::addr_w-1:0]  bus_addr,
  input  logic                           local_valid,
  input  logic [parity_pkg::data_w-1:0]  local_data,
  input  logic [parity_pkg::n_bytes-1:0] local_par,
  input  logic [parity_pkg::addr_w-1:0]  local_addr,
  input  logic                           pes_rd,
  input  logic                           pea_rd,
  output parity_pkg::pes_t               pes,
  output logic [parity_pkg::addr_w-1:0]  pea,
  output logic                           block,
  output logic                           rerr,
  output logic                           par_err
);

  logic load_pes;
  logic load_pea;
  logic mark_ovr;

  parity_err_if rep_if ();                  // Registered error report

  parity_check u_check (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus_valid   (bus_valid),
    .bus_data    (bus_data),
    .bus_par     (bus_par),
    .bus_addr    (bus_addr),
    .local_valid (local_valid),
    .local_data  (local_data),
    .local_par   (local_par),
    .local_addr  (local_addr),
    .rep         (rep_if.chk)
  );

  parity_err_ctl u_ctl (
    .clk      (clk),
    .rst_n    (rst_n),
    .test     (test),
    .pea_rd   (pea_rd),                     // Also releases the block
    .rep      (rep_if.ctl),
    .load_pes (load_pes),
    .load_pea (load_pea),
    .mark_ovr (mark_ovr),
    .block    (block),
    .rerr     (rerr),
    .par_err  (par_err)
  );

  parity_err_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .rep      (rep_if.regs),
    .load_pes (load_pes),
    .load_pea (load_pea),
    .mark_ovr (mark_ovr),
    .pes_rd   (pes_rd),
    .pea_rd   (pea_rd),
    .pes      (pes),
    .pea      (pea)
  );

endmodule

`default_nettype wire

/* hdl/parity_err_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module parity_err_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  parity_err_if.regs                    rep,
  input  logic                          load_pes,
  input  logic                          load_pea,
  input  logic                          mark_ovr,
  input  logic                          pes_rd,     // Clears overrun
  input  logic                          pea_rd,
  output parity_pkg::pes_t              pes,
  output logic [parity_pkg::addr_w-1:0] pea
);
  import parity_pkg::*;

  pes_t pes_load_word;                      // Fresh status from the report

  // Remote flag plus byte lanes, everything else zero
  always_comb begin
    pes_load_word                 = '0;
    pes_load_word[pes_remote_bit] = (rep.err_src == src_bus);
    pes_load_word[n_bytes-1:0]    = rep.byte_err;
  end

  // PES status word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pes <= '0;
    end else if (load_pes) begin
      pes <= pes_load_word;                 // Overrun starts clear
    end else if (mark_ovr) begin
      pes[pes_ovr_bit] <= 1'b1;             // Error lost while frozen
    end else if (pes_rd) begin
      pes[pes_ovr_bit] <= 1'b0;
    end
  end

  // PEA failing address
  always_ff @(posedge clk) begin
    if (!rst_n)
      pea <= '0;
    else if (load_pea)
      pea <= rep.err_addr;
  end

  a_load_pair: assert property (@(posedge clk) disable iff (!rst_n)
    load_pes == load_pea);

  // Strobes only ever follow a checker report
  a_load_has_report: assert property (@(posedge clk) disable iff (!rst_n)
    load_pes |-> rep.err_valid);

endmodule

`default_nettype wire

/* hdl/parity_err_ctl.sv */
`timescale 1ns/100ps
`default_nettype none

module parity_err_ctl (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        test,                 // Board test mode, forces quiet
  input  logic        pea_rd,               // PEA read releases the block
  parity_err_if.ctl   rep,
  output logic        load_pes,
  output logic        load_pea,
  output logic        mark_ovr,
  output logic        block,
  output logic        rerr,
  output logic        par_err
);
  import parity_pkg::*;

  ctl_state_e state;
  ctl_state_e state_nxt;
  logic       rerr_q;                       // Last error was remote
  logic       par_err_q;
  logic       rep_hit;                      // Report seen outside test mode
  logic       remote_hit;
  logic       local_hit;

  assign rep_hit    = rep.err_valid && !test;
  assign remote_hit = rep_hit && (rep.err_src == src_bus);
  assign local_hit  = rep_hit && (rep.err_src == src_local);

  // Strobes straight from the report
  assign load_pes = rep_hit && (state == st_open);
  assign load_pea = rep_hit && (state == st_open);   // Status and address move as a pair
  assign mark_ovr = rep_hit && (state == st_blocked); // Blocked, only flag the loss

  // Only a remote error freezes the registers
  always_comb begin
    state_nxt = state;
    case (state)
      st_open: begin
        if (remote_hit)
          state_nxt = st_blocked;
      end
      st_blocked: begin
        if (pea_rd)
          state_nxt = st_open;              // Software has seen the address
      end
      default: state_nxt = st_open;
    endcase
    if (test)
      state_nxt = st_open;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_open;
      rerr_q    <= 1'b0;
      par_err_q <= 1'b0;
    end else begin
      state     <= state_nxt;
      par_err_q <= rep_hit;                 // One pulse per reported error
      if (test || local_hit)
        rerr_q <= 1'b0;                     // Local error overrides remote flag
      else if (remote_hit)
        rerr_q <= 1'b1;
    end
  end

  // Test mode masks outputs right away
  assign block   = (state == st_blocked) && !test;
  assign rerr    = rerr_q && !test;
  assign par_err = par_err_q && !test;

  a_no_load_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    (state == st_blocked) |-> !load_pes);

  a_test_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    test |-> !block);

endmodule

`default_nettype wire

/* hdl/parity_check.sv */
`timescale 1ns/100ps
`default_nettype none

module parity_check (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          bus_valid,
  input  logic [parity_pkg::data_w-1:0] bus_data,
  input  logic [parity_pkg::n_bytes-1:0] bus_par,
  input  logic [parity_pkg::addr_w-1:0] bus_addr,
  input  logic                          local_valid,
  input  logic [parity_pkg::data_w-1:0] local_data,
  input  logic [parity_pkg::n_bytes-1:0] local_par,
  input  logic [parity_pkg::addr_w-1:0] local_addr,
  parity_err_if.chk                     rep
);
  import parity_pkg::*;

  logic [n_bytes-1:0] bus_bad;              // Per-byte parity failures
  logic [n_bytes-1:0] local_bad;
  logic               bus_fail;
  logic               local_fail;

  // Odd parity, so an even count of ones over byte plus parity bit is an error
  always_comb begin
    for (int i = 0; i < n_bytes; i++) begin
      bus_bad[i]   = ~^{bus_data[8*i +: 8], bus_par[i]};
      local_bad[i] = ~^{local_data[8*i +: 8], local_par[i]};
    end
  end

  assign bus_fail   = bus_valid && (|bus_bad);
  assign local_fail = local_valid && (|local_bad);

  // Event and source of the report
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rep.err_valid <= 1'b0;
      rep.err_src   <= src_none;
    end else begin
      rep.err_valid <= bus_fail || local_fail;
      if (local_fail)
        rep.err_src <= src_local;           // Local memory has priority
      else if (bus_fail)
        rep.err_src <= src_bus;
      else
        rep.err_src <= src_none;
    end
  end

  // Payload follows the same priority
  always_ff @(posedge clk) begin
    if (local_fail) begin
      rep.byte_err <= local_bad;
      rep.err_addr <= local_addr;
    end else if (bus_fail) begin
      rep.byte_err <= bus_bad;
      rep.err_addr <= bus_addr;
    end
  end

  a_src_known: assert property (@(posedge clk) disable iff (!rst_n)
    rep.err_valid |-> rep.err_src != src_none);

endmodule

`default_nettype wire

/* hdl/parity_err_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface parity_err_if;
  import parity_pkg::*;

  logic                 err_valid;          // One cycle per failing transfer
  err_src_e             err_src;            // Which side failed
  logic [n_bytes-1:0]   byte_err;           // Failing byte lanes
  logic [addr_w-1:0]    err_addr;           // Address of the failing transfer

  // Parity checker side
  modport chk (
    output err_valid, err_src, byte_err, err_addr
  );

  // Control only needs the event and its source
  modport ctl (
    input err_valid, err_src
  );

  // Register block captures the payload
  modport regs (
    input err_valid, err_src, byte_err, err_addr
  );

endinterface

`default_nettype wire

/* hdl/parity_pkg.sv */
`default_nettype none

package parity_pkg;

  // Transfer geometry
  localparam int data_w  = 16;              // Data word per transfer
  localparam int addr_w  = 24;              // Failing address width
  localparam int n_bytes = data_w / 8;      // One odd parity bit per byte

  // PES status word layout
  localparam int pes_w          = 16;
  localparam int pes_remote_bit = 15;       // Error came over the system bus
  localparam int pes_ovr_bit    = 14;       // Lost error while blocked

  // Status word, byte flags in the low bits
  typedef logic [pes_w-1:0] pes_t;

  // Capture block state
  typedef enum logic {
    st_open,                                // PES/PEA free to load
    st_blocked                              // Frozen until PEA read
  } ctl_state_e;

  // Source of a registered error report
  typedef enum logic [1:0] {
    src_none,
    src_bus,                                // Remote memory via system bus
    src_local                               // Local memory, wins on a tie
  } err_src_e;

endpackage

`default_nettype wire
